//--- common/fir_config.svh
`ifndef FIR_CONFIG_SVH
`define FIR_CONFIG_SVH

////////////////////////////////////////
// data widths
////////////////////////////////////////
`define FIR_SAMPLE_W 16 // sfix16_En15
`define FIR_COEFF_W  16 // sfix16_En16
`define FIR_OUT_W    33 // sfix33_En31
`define FIR_PROD_W   31 // kept product bits

////////////////////////////////////////
// filter shape
////////////////////////////////////////
`define FIR_TAPS   8
`define FIR_LANES  2
`define FIR_PHASES 4 // taps per lane

// symmetric coefficient set
`define FIR_COEFF_0 16'hDDBB
`define FIR_COEFF_1 16'hEA8E
`define FIR_COEFF_2 16'h33DB
`define FIR_COEFF_3 16'h6808
`define FIR_COEFF_4 16'h6808
`define FIR_COEFF_5 16'h33DB
`define FIR_COEFF_6 16'hEA8E
`define FIR_COEFF_7 16'hDDBB

`endif

//--- common/fir_pkg.sv
`default_nettype none

`include "fir_config.svh"

package fir_pkg;

  ////////////////////////////////////////
  // data path values
  ////////////////////////////////////////
  typedef logic signed [`FIR_SAMPLE_W-1:0] sample_t; // sfix16_En15
  typedef logic signed [`FIR_COEFF_W-1:0]  coeff_t;  // sfix16_En16
  typedef logic signed [`FIR_OUT_W-1:0]    acc_t;    // sfix33_En31

  ////////////////////////////////////////
  // serial control
  ////////////////////////////////////////
  typedef enum logic [1:0] {
    PH_0,
    PH_1,
    PH_2,
    PH_3
  } phase_t;

  typedef struct packed {
    phase_t phase;
    logic   first; // enabled PH_0
    logic   last;  // enabled PH_3, sample boundary
  } lane_ctrl_t;

endpackage

`default_nettype wire

//--- design/fir_phase_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fir_phase_ctrl
  import fir_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       clk_enable,
  output lane_ctrl_t ctrl
);

  phase_t phase;

  // four-phase counter, holds while disabled
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      phase <= PH_3; // first enabled edge is a sample boundary
    end else if (clk_enable) begin
      if (phase == PH_3) begin
        phase <= PH_0;
      end else begin
        phase <= phase_t'(phase + 2'd1);
      end
    end
  end

  ////////////////////////////////////////
  // strobes
  ////////////////////////////////////////
  assign ctrl.phase = phase;
  assign ctrl.first = clk_enable && (phase == PH_0); // accumulator load
  assign ctrl.last  = clk_enable && !reset && (phase == PH_3); // shift and output

endmodule

`default_nettype wire

//--- design/fir_tap_line.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_config.svh"

module fir_tap_line
  import fir_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  lane_ctrl_t ctrl,
  input  sample_t    filter_in,
  output sample_t    tap_a,
  output sample_t    tap_b
);

  sample_t taps     [`FIR_TAPS];
  sample_t lane_tap [`FIR_LANES];

  // delay line, one shift per sample
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `FIR_TAPS; i++) begin
        taps[i] <= '0;
      end
    end else if (ctrl.last) begin
      taps[0] <= filter_in;
      for (int i = 1; i < `FIR_TAPS; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  ////////////////////////////////////////
  // per-lane tap select
  ////////////////////////////////////////
  always_comb begin
    for (int l = 0; l < `FIR_LANES; l++) begin
      lane_tap[l] = taps[l * `FIR_PHASES + int'(ctrl.phase)];
    end
  end

  assign tap_a = lane_tap[0]; // taps 0..3
  assign tap_b = lane_tap[1]; // taps 4..7

endmodule

`default_nettype wire

//--- mac/vedic_mult.sv
`timescale 1ns/1ps
`default_nettype none

module vedic_mult #(
  parameter int width = 16
) (
  input  logic [width-1:0]   a,
  input  logic [width-1:0]   b,
  output logic [2*width-1:0] product
);

  if (width == 2) begin : g_base
    logic cross_lo;
    logic cross_hi;
    logic top;
    logic carry;

    // 2x2 cell from AND terms
    assign cross_lo   = a[1] & b[0];
    assign cross_hi   = a[0] & b[1];
    assign top        = a[1] & b[1];
    assign carry      = cross_lo & cross_hi;
    assign product[0] = a[0] & b[0];
    assign product[1] = cross_lo ^ cross_hi;
    assign product[2] = top ^ carry;
    assign product[3] = top & carry;
  end else begin : g_split
    localparam int half = width / 2;

    logic [width-1:0]      q_ll; // a lo * b lo
    logic [width-1:0]      q_hl; // a hi * b lo
    logic [width-1:0]      q_lh; // a lo * b hi
    logic [width-1:0]      q_hh; // a hi * b hi
    logic [width-1:0]      low_sum;
    logic [width+half-1:0] high_sum;
    logic [width+half-1:0] total;

    vedic_mult #(.width(half)) u_ll (.a(a[half-1:0]),     .b(b[half-1:0]),     .product(q_ll));
    vedic_mult #(.width(half)) u_hl (.a(a[width-1:half]), .b(b[half-1:0]),     .product(q_hl));
    vedic_mult #(.width(half)) u_lh (.a(a[half-1:0]),     .b(b[width-1:half]), .product(q_lh));
    vedic_mult #(.width(half)) u_hh (.a(a[width-1:half]), .b(b[width-1:half]), .product(q_hh));

    ////////////////////////////////////////
    // vedic column sums
    ////////////////////////////////////////
    assign low_sum  = {{half{1'b0}}, q_ll[width-1:half]} + q_hl; // never overflows
    assign high_sum = {{half{1'b0}}, q_lh} + {q_hh, {half{1'b0}}};
    assign total    = {{half{1'b0}}, low_sum} + high_sum;
    assign product  = {total, q_ll[half-1:0]};
  end

endmodule

`default_nettype wire

//--- mac/fir_mac_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_config.svh"

module fir_mac_lane
  import fir_pkg::*;
#(
  parameter int lane_index = 0
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       clk_enable,
  input  lane_ctrl_t ctrl,
  input  sample_t    tap,
  output acc_t       sum
);

  localparam int base = lane_index * `FIR_PHASES;

  localparam coeff_t coeff_rom [`FIR_TAPS] = '{
    `FIR_COEFF_0, `FIR_COEFF_1, `FIR_COEFF_2, `FIR_COEFF_3,
    `FIR_COEFF_4, `FIR_COEFF_5, `FIR_COEFF_6, `FIR_COEFF_7
  };

  coeff_t                          coeff;
  logic [`FIR_SAMPLE_W-1:0]        tap_mag;
  logic [`FIR_COEFF_W-1:0]         coeff_mag;
  logic [2*`FIR_SAMPLE_W-1:0]      mag_prod;
  logic [2*`FIR_SAMPLE_W-1:0]      signed_prod;
  logic                            negate;
  logic signed [`FIR_PROD_W-1:0]   product;
  acc_t                            product_ext;
  acc_t                            acc;

  assign coeff = coeff_rom[base + int'(ctrl.phase)];

  ////////////////////////////////////////
  // sign and magnitude multiply
  ////////////////////////////////////////
  assign tap_mag   = tap[`FIR_SAMPLE_W-1] ? -tap : tap; // 0x8000 stays 32768
  assign coeff_mag = coeff[`FIR_COEFF_W-1] ? -coeff : coeff;
  assign negate    = tap[`FIR_SAMPLE_W-1] ^ coeff[`FIR_COEFF_W-1];

  vedic_mult #(
    .width(`FIR_SAMPLE_W)
  ) u_mult (
    .a      (tap_mag),
    .b      (coeff_mag),
    .product(mag_prod)
  );

  assign signed_prod = negate ? -mag_prod : mag_prod;
  assign product     = signed_prod[`FIR_PROD_W-1:0]; // sfix31_En31
  assign product_ext = {{(`FIR_OUT_W-`FIR_PROD_W){product[`FIR_PROD_W-1]}}, product};

  // load on first phase, add on the rest
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      acc <= '0;
    end else if (ctrl.first) begin
      acc <= product_ext;
    end else if (clk_enable) begin
      acc <= acc + product_ext;
    end
  end

  assign sum = acc;

endmodule

`default_nettype wire

//--- design/fir_serial_top.sv
`timescale 1ns/1ps
`default_nettype none

module fir_serial_top
  import fir_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    clk_enable,
  input  sample_t filter_in,
  output acc_t    filter_out,
  output logic    out_strobe
);

  lane_ctrl_t ctrl;
  sample_t    tap_a;
  sample_t    tap_b;
  acc_t       sum_a;
  acc_t       sum_b;
  acc_t       lane_sum;
  acc_t       final_sum;

  fir_phase_ctrl u_phase_ctrl (
    .clk       (clk),
    .reset     (reset),
    .clk_enable(clk_enable),
    .ctrl      (ctrl)
  );

  fir_tap_line u_tap_line (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl),
    .filter_in(filter_in),
    .tap_a    (tap_a),
    .tap_b    (tap_b)
  );

  fir_mac_lane #(.lane_index(0)) u_lane0 (
    .clk       (clk),
    .reset     (reset),
    .clk_enable(clk_enable),
    .ctrl      (ctrl),
    .tap       (tap_a),
    .sum       (sum_a)
  );

  fir_mac_lane #(.lane_index(1)) u_lane1 (
    .clk       (clk),
    .reset     (reset),
    .clk_enable(clk_enable),
    .ctrl      (ctrl),
    .tap       (tap_b),
    .sum       (sum_b)
  );

  ////////////////////////////////////////
  // lane sum and output stage
  ////////////////////////////////////////
  assign lane_sum = sum_a + sum_b;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      final_sum  <= '0;
      filter_out <= '0;
    end else begin
      if (ctrl.first) begin
        final_sum <= lane_sum; // lanes finished on previous edge
      end
      if (ctrl.last) begin
        filter_out <= final_sum;
      end
    end
  end

  assign out_strobe = ctrl.last;

endmodule

`default_nettype wire

//--- sim/fir_props.sv
`timescale 1ns/1ps
`default_nettype none

module fir_props
  import fir_pkg::*;
(
  input logic clk,
  input logic reset,
  input logic clk_enable,
  input acc_t filter_out,
  input logic out_strobe
);

  strobe_low_in_reset: assert property (@(posedge clk) reset |-> !out_strobe)
    else $error("out_strobe high while reset is held");

  // output register only moves on a strobe edge
  output_holds: assert property (@(posedge clk) disable iff (reset)
    !out_strobe |=> $stable(filter_out))
    else $error("filter_out changed without out_strobe");

  ////////////////////////////////////////
  // strobe spacing with enable held high
  ////////////////////////////////////////
  strobe_period: assert property (@(posedge clk) disable iff (reset)
    ($past(out_strobe, 4) && $past(clk_enable, 3) && $past(clk_enable, 2)
      && $past(clk_enable, 1) && clk_enable)
    |-> (out_strobe && !$past(out_strobe, 1) && !$past(out_strobe, 2)
      && !$past(out_strobe, 3)))
    else $error("out_strobe not spaced by four enabled cycles");

endmodule

`default_nettype wire

//--- sim/fir_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_config.svh"

module fir_checker
  import fir_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  sample_t filter_in,
  input  acc_t    filter_out,
  input  logic    out_strobe,
  input  int      test_id,
  input  logic    test_end,
  output int      check_count,
  output int      error_count
);

  localparam coeff_t coeffs [`FIR_TAPS] = '{
    `FIR_COEFF_0, `FIR_COEFF_1, `FIR_COEFF_2, `FIR_COEFF_3,
    `FIR_COEFF_4, `FIR_COEFF_5, `FIR_COEFF_6, `FIR_COEFF_7
  };

  sample_t history [$]; // captured samples since reset
  int      checks = 0;
  int      compare_errors = 0;
  int      reset_errors = 0;
  int      test_checks = 0;
  int      test_errors = 0;
  logic    check_pending = 1'b0;
  int      check_index;
  int      check_test;
  acc_t    expected;

  assign check_count = checks;
  assign error_count = compare_errors + reset_errors;

  function automatic string test_name(input int id);
    case (id)
      1:       return "impulse";
      2:       return "random_stream";
      3:       return "enable_gaps";
      4:       return "extremes";
      5:       return "midrun_reset";
      default: return "idle";
    endcase
  endfunction

  // y[k] = sum of c[i] * x[k-i], full precision
  function automatic acc_t reference_output(input int k);
    longint total;
    total = 0;
    for (int i = 0; i < `FIR_TAPS; i++) begin
      if (k - i >= 0) begin
        total += longint'(coeffs[i]) * longint'(history[k-i]);
      end
    end
    return acc_t'(total);
  endfunction

  ////////////////////////////////////////
  // capture and compare
  ////////////////////////////////////////
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      history.delete(); // pipeline restarts from zeros
      check_pending <= 1'b0;
    end else begin
      if (check_pending) begin
        expected = (check_index < 2) ? '0 : reference_output(check_index - 2);
        checks++;
        test_checks++;
        if (filter_out !== expected) begin
          compare_errors++;
          test_errors++;
          $display("Error: test %s, output %0d: expected %0d, actual %0d",
                   test_name(check_test), check_index, expected, filter_out);
        end
      end
      check_pending <= out_strobe; // output settles one edge later
      if (out_strobe) begin
        check_index <= history.size();
        check_test  <= test_id;
        history.push_back(filter_in);
      end
      if (test_end) begin
        $display("test %s done: %0d checks, %0d errors",
                 test_name(test_id), test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
      end
    end
  end

  // registers must read zero while reset is held
  always @(posedge clk) begin
    if (reset && filter_out !== '0) begin
      reset_errors++;
      $display("Error: test %s, reset: expected 0, actual %0d",
               test_name(test_id), filter_out);
    end
  end

endmodule

`default_nettype wire

//--- sim/fir_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_config.svh"

module fir_tb
  import fir_pkg::*;
();

  localparam int reset_cycles  = 16;
  localparam int impulse_len   = 12;
  localparam int random_len    = 64;
  localparam int gap_len       = 40;
  localparam int extreme_len   = 24;
  localparam int restart_len   = 18;
  localparam int total_samples = impulse_len + random_len + gap_len + extreme_len + restart_len;
  localparam int cycle_limit   = total_samples * `FIR_PHASES * 3 + 200;

  logic    clk = 1'b0;
  logic    reset;
  logic    clk_enable;
  sample_t filter_in;
  acc_t    filter_out;
  logic    out_strobe;
  int      test_id;
  logic    test_end;
  int      check_count;
  int      error_count;
  int      seed;
  int      idle_left = 0;
  int      strobe_count = 0;
  int      cycle_count = 0;

  always #4 clk = ~clk; // 8 ns period

  fir_serial_top u_fir_serial_top (
    .clk       (clk),
    .reset     (reset),
    .clk_enable(clk_enable),
    .filter_in (filter_in),
    .filter_out(filter_out),
    .out_strobe(out_strobe)
  );

  fir_checker u_checker (
    .clk        (clk),
    .reset      (reset),
    .filter_in  (filter_in),
    .filter_out (filter_out),
    .out_strobe (out_strobe),
    .test_id    (test_id),
    .test_end   (test_end),
    .check_count(check_count),
    .error_count(error_count)
  );

  bind fir_serial_top fir_props u_props (
    .clk       (clk),
    .reset     (reset),
    .clk_enable(clk_enable),
    .filter_out(filter_out),
    .out_strobe(out_strobe)
  );

  always @(posedge clk) begin
    if (out_strobe) begin
      strobe_count <= strobe_count + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the filter stopped producing outputs after %0d cycles", cycle_limit);
      $display("Test failures found");
      $finish;
    end
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////
  task automatic drive_enable(input bit gaps);
    if (gaps && idle_left > 0) begin
      clk_enable = 1'b0;
      idle_left--;
    end else begin
      clk_enable = 1'b1;
      if (gaps) begin
        idle_left = $random(seed) & 3; // 0 to 3 idle cycles
      end
    end
  endtask

  // hold the sample until the DUT takes it
  task automatic send_sample(input sample_t value, input bit gaps);
    int start;
    start = strobe_count;
    filter_in = value;
    while (strobe_count == start) begin
      drive_enable(gaps);
      @(negedge clk);
    end
  endtask

  task automatic finish_test();
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  // enable stays high inside reset, strobe must stay low
  task automatic apply_reset(input int cycles);
    clk_enable = 1'b0;
    @(negedge clk);
    reset = 1'b1;
    clk_enable = 1'b1;
    repeat (cycles) @(negedge clk);
    clk_enable = 1'b0;
    reset = 1'b0;
  endtask

  initial begin
    seed       = 24112;
    reset      = 1'b1;
    clk_enable = 1'b0;
    filter_in  = '0;
    test_id    = 0;
    test_end   = 1'b0;
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;

    test_id = 1; // outputs trace the coefficients
    send_sample(sample_t'(16'h4000), 1'b0);
    repeat (impulse_len - 1) send_sample('0, 1'b0);
    finish_test();

    test_id = 2;
    repeat (random_len) send_sample(sample_t'($random(seed)), 1'b0);
    finish_test();

    test_id = 3;
    repeat (gap_len) send_sample(sample_t'($random(seed)), 1'b1);
    finish_test();

    test_id = 4; // full-scale negative and positive
    for (int i = 0; i < extreme_len; i++) begin
      send_sample((i % 2) ? sample_t'(16'h7FFF) : sample_t'(16'h8000), 1'b0);
    end
    finish_test();

    test_id = 5;
    apply_reset(4);
    repeat (restart_len - 2) send_sample(sample_t'($random(seed)), 1'b0);
    repeat (2) send_sample('0, 1'b0);
    finish_test();

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+common
common/fir_pkg.sv
design/fir_phase_ctrl.sv
design/fir_tap_line.sv
mac/vedic_mult.sv
mac/fir_mac_lane.sv
design/fir_serial_top.sv
sim/fir_props.sv
sim/fir_checker.sv
sim/fir_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FIR testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module fir_tb -f files.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vfir_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi
